// ==== filelist.f ====
+incdir+source
source/odd_pipe_pkg.sv
source/odd_issue_if.sv
source/odd_decode.sv
source/permute_execute.sv
source/branch_execute.sv
source/forward_pipe.sv
source/odd_pipe_top.sv
tb/odd_pipe_tb.sv

// ==== tb/odd_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module odd_pipe_tb;
    import odd_pipe_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_INSTR = 200 + 48 + 96 + 120;
    localparam int DRAIN = 12;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_INSTR + 5 * DRAIN + 40;

    logic                   clock = 1'b0;
    logic                   reset;
    opcode_t                op;
    logic [0:`ODD_QUAD_W-1] ra;
    logic [0:`ODD_QUAD_W-1] rb;
    logic [0:6]             i7;
    logic [0:15]            i16;
    logic [0:`ODD_RT_W-1]   rt_addr;
    logic [0:`ODD_ADDR_W-1] pc;
    logic                   branch_taken;
    logic [0:`ODD_ADDR_W-1] pc_out;
    fw_entry_t              fw_stages [1:`ODD_FW_DEPTH];

    integer seed;
    int     cycle = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     fails_at_start = 0;

    // expected results waiting for stage 1 and for stage 7
    fw_entry_t   exp1_q [$];
    logic        exp_taken_q [$];
    logic [0:31] exp_pc_q [$];
    int          due1_q [$];
    fw_entry_t   exp7_q [$];
    int          due7_q [$];

    odd_pipe_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .op           (op),
        .ra           (ra),
        .rb           (rb),
        .i7           (i7),
        .i16          (i16),
        .rt_addr      (rt_addr),
        .pc           (pc),
        .branch_taken (branch_taken),
        .pc_out       (pc_out),
        .fw_stages    (fw_stages)
    );

    always #4 clock = ~clock;

    always @(posedge clock)
        cycle <= cycle + 1;

    // expected stage 1 entry, taken flag and next pc for one instruction
    function automatic fw_entry_t ref_model(
        input opcode_t op_v,
        input logic [0:127] ra_v,
        input logic [0:127] rb_v,
        input logic [0:6] i7_v,
        input logic [0:15] i16_v,
        input logic [0:6] rt_v,
        input logic [0:31] pc_v,
        output logic taken,
        output logic [0:31] next_pc
    );
        fw_entry_t   e;
        logic [31:0] rb_word;
        logic [31:0] ra_word;
        logic [31:0] imm_val;
        logic [31:0] offset;
        logic [31:0] gathered;
        logic        cond;
        int          count;
        int          amt;
        int          size;
        begin
            e = '0;
            e.rt_addr = rt_v;
            taken = 1'b0;
            next_pc = '0;
            rb_word = rb_v[0:31];
            ra_word = ra_v[0:31];
            imm_val = {25'd0, i7_v};
            count = 0;
            size = 0;
            cond = 1'b1;
            case (op_v)
                OP_SHLQBI, OP_ROTQBI:   count = rb_word % 8;
                OP_SHLQBII, OP_ROTQBII: count = imm_val % 8;
                OP_SHLQBY:              count = rb_word % 32;
                OP_SHLQBYI:             count = imm_val % 32;
                OP_ROTQBY:              count = rb_word % 16;
                OP_ROTQBYI:             count = imm_val % 16;
                OP_SHLQBYBI:            count = (rb_word >> 3) % 32;
                OP_ROTQBYBI:            count = (rb_word >> 3) % 16;
                OP_GBB:                 size = 8;
                OP_GBH:                 size = 16;
                OP_GB:                  size = 32;
                default: ;
            endcase
            if (op_v inside {OP_SHLQBY, OP_SHLQBYI, OP_SHLQBYBI,
                             OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI})
                amt = count * 8;
            else
                amt = count;

            if (op_v inside {[OP_SHLQBI:OP_GB]})
            begin
                e.uid = `ODD_PERM_UID;
                e.latency = `ODD_PERM_LAT;
                e.wr_en = 1'b1;
            end
            if (op_v inside {[OP_SHLQBI:OP_SHLQBYBI]})
            begin
                for (int i = 0; i < 128; i++)
                    e.value[i] = (i + amt < 128) ? ra_v[i + amt] : 1'b0;
            end
            else if (op_v inside {[OP_ROTQBI:OP_ROTQBYBI]})
            begin
                for (int i = 0; i < 128; i++)
                    e.value[i] = ra_v[(i + amt) % 128];
            end
            else if (size != 0)
            begin
                // lsb of each element with the first element most significant
                gathered = '0;
                for (int j = 0; j < 128 / size; j++)
                    gathered = (gathered << 1) | ra_v[j * size + size - 1];
                e.value[0:31] = gathered;
            end
            else if (op_v != OP_NOP)
            begin
                e.uid = `ODD_BR_UID;
                e.latency = `ODD_BR_LAT;
                offset = {{16{i16_v[0]}}, i16_v} << 2;
                case (op_v)
                    OP_BRZ:   cond = (ra_word == 0);
                    OP_BRNZ:  cond = (ra_word != 0);
                    OP_BRHZ:  cond = ((ra_word & 32'h0000_ffff) == 0);
                    OP_BRHNZ: cond = ((ra_word & 32'h0000_ffff) != 0);
                    default:  cond = 1'b1;
                endcase
                taken = cond;
                if (op_v == OP_BRA || op_v == OP_BRASL)
                    next_pc = offset;
                else if (op_v == OP_BR || op_v == OP_BRSL)
                    next_pc = pc_v + offset;
                else if (cond)
                    next_pc = (pc_v + offset) & ~32'd3;
                else
                    next_pc = pc_v + 32'd4;
                if (op_v == OP_BRSL || op_v == OP_BRASL)
                begin
                    e.wr_en = 1'b1;
                    e.value[0:31] = pc_v + 32'd4;
                end
            end
            return e;
        end
    endfunction

    function automatic logic [0:127] rand_quad();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check_value(input string name, input logic [142:0] expected,
                               input logic [142:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            fail_count++;
        end
        else
            pass_count++;
    endtask

    // drive one instruction and queue what the pipe should show for it
    task automatic issue_instr(input opcode_t op_v, input logic [0:127] ra_v,
                               input logic [0:127] rb_v, input logic [0:6] i7_v,
                               input logic [0:15] i16_v, input logic [0:6] rt_v,
                               input logic [0:31] pc_v);
        fw_entry_t   e;
        logic        taken_v;
        logic [0:31] npc;
        @(posedge clock);
        op <= op_v;
        ra <= ra_v;
        rb <= rb_v;
        i7 <= i7_v;
        i16 <= i16_v;
        rt_addr <= rt_v;
        pc <= pc_v;
        e = ref_model(op_v, ra_v, rb_v, i7_v, i16_v, rt_v, pc_v, taken_v, npc);
        exp1_q.push_back(e);
        exp_taken_q.push_back(taken_v);
        exp_pc_q.push_back(npc);
        due1_q.push_back(cycle + 2);
    endtask

    task automatic finish_test(input string name);
        @(posedge clock);
        op <= OP_NOP;
        while (due1_q.size() != 0 || due7_q.size() != 0)
            @(negedge clock);
        @(posedge clock);
        $display("test %s done, %0d mismatches", name, fail_count - fails_at_start);
        fails_at_start = fail_count;
    endtask

    always @(negedge clock)
    begin : compare_results
        fw_entry_t e;
        if (due1_q.size() != 0 && due1_q[0] == cycle)
        begin
            void'(due1_q.pop_front());
            e = exp1_q.pop_front();
            check_value("fw_stages[1]", e, fw_stages[1]);
            check_value("branch_taken", exp_taken_q.pop_front(), branch_taken);
            check_value("pc_out", exp_pc_q.pop_front(), pc_out);
            exp7_q.push_back(e);
            due7_q.push_back(cycle + 6);
        end
        if (due7_q.size() != 0 && due7_q[0] == cycle)
        begin
            void'(due7_q.pop_front());
            check_value("fw_stages[7]", exp7_q.pop_front(), fw_stages[7]);
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired before all expected results were checked");
        $display("Test failed");
        $finish;
    end

    initial
    begin : main
        logic [0:127] ra_v;
        logic [0:127] rb_v;
        logic [0:6]   i7_v;
        logic [4:0]   c;
        opcode_t      op_v;
        seed = 32'h6d5c_148a;
        reset = 1'b1;
        // a link branch sits at the inputs for the whole reset
        op = OP_BRASL;
        ra = '0;
        rb = '0;
        i7 = '0;
        i16 = 16'h0040;
        rt_addr = '0;
        pc = 32'h0000_1000;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        op <= OP_NOP;

        // idle pipe straight after reset
        @(negedge clock);
        for (int n = 1; n <= `ODD_FW_DEPTH; n++)
        begin
            check_value($sformatf("fw_stages[%0d].uid", n), 0, fw_stages[n].uid);
            check_value($sformatf("fw_stages[%0d].wr_en", n), 0, fw_stages[n].wr_en);
        end
        check_value("branch_taken", 0, branch_taken);
        check_value("pc_out", 0, pc_out);
        finish_test("reset");

        // first 40 force the count edge cases 0, 15, 16 and 31
        for (int n = 0; n < 200; n++)
        begin
            op_v = opcode_t'(OP_SHLQBI + n % 10);
            ra_v = rand_quad();
            rb_v = rand_quad();
            i7_v = $random(seed);
            if (n < 40)
            begin
                case (n / 10)
                    0: c = 5'd0;
                    1: c = 5'd15;
                    2: c = 5'd16;
                    default: c = 5'd31;
                endcase
                if (op_v == OP_SHLQBYBI || op_v == OP_ROTQBYBI)
                    rb_v[24:28] = c;
                else
                    rb_v[27:31] = c;
                i7_v[2:6] = c;
            end
            issue_instr(op_v, ra_v, rb_v, i7_v, $random(seed), $random(seed), $random(seed));
        end
        finish_test("shift_rotate");

        for (int n = 0; n < 48; n++)
        begin
            ra_v = rand_quad();
            if (n < 3)
                ra_v = '1;
            issue_instr(opcode_t'(OP_GBB + n % 3), ra_v, rand_quad(), $random(seed),
                        $random(seed), $random(seed), $random(seed));
        end
        finish_test("gather");

        for (int n = 0; n < 96; n++)
        begin
            ra_v = rand_quad();
            case ((n / 8) % 4)
                0: ra_v[0:31] = '0;
                1: ra_v[31] = 1'b1;
                2:
                begin
                    // word nonzero but halfword zero
                    ra_v[16:31] = '0;
                    ra_v[0] = 1'b1;
                end
                default: ;
            endcase
            issue_instr(opcode_t'(OP_BR + n % 8), ra_v, rand_quad(), $random(seed),
                        $random(seed), $random(seed), $random(seed));
        end
        finish_test("branch");

        // every third slot is a bubble
        for (int n = 0; n < 120; n++)
        begin
            if (n % 3 == 2)
                op_v = OP_NOP;
            else
                op_v = opcode_t'($unsigned($random(seed)) % 22);
            issue_instr(op_v, rand_quad(), rand_quad(), $random(seed),
                        $random(seed), $random(seed), $random(seed));
        end
        finish_test("back_to_back");

        $display("checks passed %0d, mismatched %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/odd_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module odd_pipe_top (
    input  logic                    clock,
    input  logic                    reset,
    input  odd_pipe_pkg::opcode_t   op,
    input  logic [0:`ODD_QUAD_W-1]  ra,
    input  logic [0:`ODD_QUAD_W-1]  rb,
    input  logic [0:6]              i7,
    input  logic [0:15]             i16,
    input  logic [0:`ODD_RT_W-1]    rt_addr,
    input  logic [0:`ODD_ADDR_W-1]  pc,
    output logic                    branch_taken,
    output logic [0:`ODD_ADDR_W-1]  pc_out,
    output odd_pipe_pkg::fw_entry_t fw_stages [1:`ODD_FW_DEPTH]
);

    logic [0:`ODD_QUAD_W-1] perm_value;
    logic [0:`ODD_QUAD_W-1] link_value;

    // decoded instruction shared by the execute and result blocks
    odd_issue_if issue_bus ();

    odd_decode i_decode (
        .clock   (clock),
        .reset   (reset),
        .op      (op),
        .ra      (ra),
        .rb      (rb),
        .i7      (i7),
        .i16     (i16),
        .rt_addr (rt_addr),
        .pc      (pc),
        .issue   (issue_bus.decode)
    );

    permute_execute i_permute (
        .issue      (issue_bus.perm),
        .perm_value (perm_value)
    );

    branch_execute i_branch (
        .issue        (issue_bus.branch),
        .branch_taken (branch_taken),
        .pc_out       (pc_out),
        .link_value   (link_value)
    );

    forward_pipe i_forward (
        .clock      (clock),
        .reset      (reset),
        .issue      (issue_bus.result),
        .perm_value (perm_value),
        .link_value (link_value),
        .fw_stages  (fw_stages)
    );

endmodule

`default_nettype wire

// ==== source/forward_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module forward_pipe (
    input  logic                   clock,
    input  logic                   reset,
    odd_issue_if.result            issue,
    input  logic [0:`ODD_QUAD_W-1] perm_value,
    input  logic [0:`ODD_QUAD_W-1] link_value,
    output odd_pipe_pkg::fw_entry_t fw_stages [1:`ODD_FW_DEPTH]
);
    import odd_pipe_pkg::*;

    fw_entry_t stage_1;
    fw_entry_t stage_q [2:`ODD_FW_DEPTH];

    // stage 1 entry straight from the execute units
    always_comb
    begin
        stage_1         = '0;
        stage_1.rt_addr = issue.rt_addr;
        case (issue.unit)
            UNIT_PERM:
            begin
                stage_1.uid     = `ODD_UID_W'(`ODD_PERM_UID);
                stage_1.latency = `ODD_LAT_W'(`ODD_PERM_LAT);
                stage_1.value   = perm_value;
                stage_1.wr_en   = 1'b1;
            end
            UNIT_BRANCH:
            begin
                stage_1.uid     = `ODD_UID_W'(`ODD_BR_UID);
                stage_1.latency = `ODD_LAT_W'(`ODD_BR_LAT);
                // only the link forms write a register
                stage_1.value   = issue.set_link ? link_value : '0;
                stage_1.wr_en   = issue.set_link;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int n = 2; n <= `ODD_FW_DEPTH; n++)
                stage_q[n] <= '0;
        end
        else
        begin
            stage_q[2] <= stage_1;
            for (int n = 3; n <= `ODD_FW_DEPTH; n++)
                stage_q[n] <= stage_q[n - 1];
        end
    end

    always_comb
    begin
        fw_stages[1] = stage_1;
        for (int n = 2; n <= `ODD_FW_DEPTH; n++)
            fw_stages[n] = stage_q[n];
    end

endmodule

`default_nettype wire

// ==== source/branch_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module branch_execute (
    odd_issue_if.branch            issue,
    output logic                   branch_taken,
    output logic [0:`ODD_ADDR_W-1] pc_out,
    output logic [0:`ODD_QUAD_W-1] link_value
);
    import odd_pipe_pkg::*;

    logic [0:`ODD_ADDR_W-1] offset;
    logic [0:`ODD_ADDR_W-1] rel_target;
    logic [0:`ODD_ADDR_W-1] seq_pc;
    logic                   cond_met;

    // word offset from the 16 bit immediate
    assign offset     = {{14{issue.imm16[0]}}, issue.imm16, 2'b00};
    assign rel_target = issue.pc + offset;
    assign seq_pc     = issue.pc + 32'd4;

    // conditions test the preferred word of ra
    always_comb
    begin
        case (issue.branch_kind)
            BK_ZERO_WORD: cond_met = (issue.ra[0:31] == 32'd0);
            BK_NZ_WORD:   cond_met = (issue.ra[0:31] != 32'd0);
            BK_ZERO_HALF: cond_met = (issue.ra[16:31] == 16'd0);
            BK_NZ_HALF:   cond_met = (issue.ra[16:31] != 16'd0);
            default:      cond_met = 1'b1;
        endcase
    end

    always_comb
    begin
        branch_taken = 1'b0;
        pc_out       = '0;
        if (issue.unit == UNIT_BRANCH)
        begin
            if (issue.branch_kind == BK_REL)
            begin
                branch_taken = 1'b1;
                pc_out       = rel_target;
            end
            else if (issue.branch_kind == BK_ABS)
            begin
                branch_taken = 1'b1;
                pc_out       = offset;
            end
            else if (cond_met)
            begin
                // taken target is word aligned
                branch_taken = 1'b1;
                pc_out       = {rel_target[0:`ODD_ADDR_W-3], 2'b00};
            end
            else
            begin
                pc_out = seq_pc;
            end
        end
    end

    assign link_value = {seq_pc, {(`ODD_QUAD_W - `ODD_ADDR_W){1'b0}}};

endmodule

`default_nettype wire

// ==== source/permute_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module permute_execute (
    odd_issue_if.perm              issue,
    output logic [0:`ODD_QUAD_W-1] perm_value
);
    import odd_pipe_pkg::*;

    // shift amount in bits, byte counts up to 31 give 248
    logic [7:0]             amount;
    logic [0:`ODD_QUAD_W-1] shifted;
    logic [0:`ODD_QUAD_W-1] rotated;
    logic [0:`ODD_QUAD_W-1] gather_b;
    logic [0:`ODD_QUAD_W-1] gather_h;
    logic [0:`ODD_QUAD_W-1] gather_w;

    always_comb
    begin
        case (issue.perm_kind)
            PK_SHIFT_BYTES, PK_ROT_BYTES: amount = {issue.shift_count, 3'b000};
            default:                      amount = {3'b000, issue.shift_count};
        endcase
    end

    // left means toward bit 0, zeros fill from the bottom
    assign shifted = issue.ra << amount;

    // bits leaving bit 0 come back at bit 127, amount of 0 drops the second term
    assign rotated = shifted | (issue.ra >> (8'd128 - amount));

    // element 0 lands in the highest gathered bit of the preferred word
    always_comb
    begin
        gather_b = '0;
        for (int j = 0; j < 16; j++)
        begin
            gather_b[16 + j] = issue.ra[j * 8 + 7];
        end
    end

    always_comb
    begin
        gather_h = '0;
        for (int j = 0; j < 8; j++)
        begin
            gather_h[24 + j] = issue.ra[j * 16 + 15];
        end
    end

    always_comb
    begin
        gather_w = '0;
        for (int j = 0; j < 4; j++)
        begin
            gather_w[28 + j] = issue.ra[j * 32 + 31];
        end
    end

    always_comb
    begin
        if (issue.unit != UNIT_PERM)
        begin
            perm_value = '0;
        end
        else
        begin
            case (issue.perm_kind)
                PK_SHIFT_BITS, PK_SHIFT_BYTES: perm_value = shifted;
                PK_ROT_BITS, PK_ROT_BYTES:     perm_value = rotated;
                PK_GATHER_BYTES:               perm_value = gather_b;
                PK_GATHER_HALFS:               perm_value = gather_h;
                PK_GATHER_WORDS:               perm_value = gather_w;
                default:                       perm_value = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/odd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module odd_decode (
    input  logic                   clock,
    input  logic                   reset,
    input  odd_pipe_pkg::opcode_t  op,
    input  logic [0:`ODD_QUAD_W-1] ra,
    input  logic [0:`ODD_QUAD_W-1] rb,
    input  logic [0:6]             i7,
    input  logic [0:15]            i16,
    input  logic [0:`ODD_RT_W-1]   rt_addr,
    input  logic [0:`ODD_ADDR_W-1] pc,
    odd_issue_if.decode            issue
);
    import odd_pipe_pkg::*;

    opcode_t                op_q;
    logic [0:`ODD_QUAD_W-1] ra_q;
    logic [0:`ODD_QUAD_W-1] rb_q;
    logic [0:6]             i7_q;
    logic [0:15]            i16_q;
    logic [0:`ODD_RT_W-1]   rt_addr_q;
    logic [0:`ODD_ADDR_W-1] pc_q;

    // opcode comes up as a bubble after reset
    always_ff @(posedge clock)
    begin
        if (reset)
            op_q <= OP_NOP;
        else
            op_q <= op;
    end

    always_ff @(posedge clock)
    begin
        ra_q      <= ra;
        rb_q      <= rb;
        i7_q      <= i7;
        i16_q     <= i16;
        rt_addr_q <= rt_addr;
        pc_q      <= pc;
    end

    assign issue.ra       = ra_q;
    assign issue.imm16    = i16_q;
    assign issue.pc       = pc_q;
    assign issue.rt_addr  = rt_addr_q;
    assign issue.set_link = (op_q == OP_BRSL) || (op_q == OP_BRASL);

    always_comb
    begin
        issue.unit        = UNIT_NONE;
        issue.perm_kind   = PK_SHIFT_BITS;
        issue.branch_kind = BK_REL;
        issue.shift_count = 5'd0;

        case (op_q)
            OP_SHLQBI, OP_SHLQBII, OP_SHLQBY, OP_SHLQBYI, OP_SHLQBYBI,
            OP_ROTQBI, OP_ROTQBII, OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI,
            OP_GBB, OP_GBH, OP_GB:
                issue.unit = UNIT_PERM;
            OP_BR, OP_BRA, OP_BRSL, OP_BRASL, OP_BRZ, OP_BRNZ, OP_BRHZ, OP_BRHNZ:
                issue.unit = UNIT_BRANCH;
            default: issue.unit = UNIT_NONE;
        endcase

        case (op_q)
            OP_SHLQBY, OP_SHLQBYI, OP_SHLQBYBI:    issue.perm_kind = PK_SHIFT_BYTES;
            OP_ROTQBI, OP_ROTQBII:                 issue.perm_kind = PK_ROT_BITS;
            OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI:    issue.perm_kind = PK_ROT_BYTES;
            OP_GBB:                                issue.perm_kind = PK_GATHER_BYTES;
            OP_GBH:                                issue.perm_kind = PK_GATHER_HALFS;
            OP_GB:                                 issue.perm_kind = PK_GATHER_WORDS;
            OP_BRA, OP_BRASL:                      issue.branch_kind = BK_ABS;
            OP_BRZ:                                issue.branch_kind = BK_ZERO_WORD;
            OP_BRNZ:                               issue.branch_kind = BK_NZ_WORD;
            OP_BRHZ:                               issue.branch_kind = BK_ZERO_HALF;
            OP_BRHNZ:                              issue.branch_kind = BK_NZ_HALF;
            default: ;
        endcase

        // count source, rb counts come from the preferred word
        case (op_q)
            OP_SHLQBI, OP_ROTQBI:   issue.shift_count = {2'b00, rb_q[29:31]};
            OP_SHLQBII, OP_ROTQBII: issue.shift_count = {2'b00, i7_q[4:6]};
            OP_SHLQBY:              issue.shift_count = rb_q[27:31];
            OP_SHLQBYI:             issue.shift_count = i7_q[2:6];
            OP_ROTQBY:              issue.shift_count = {1'b0, rb_q[28:31]};
            OP_ROTQBYI:             issue.shift_count = {1'b0, i7_q[3:6]};
            OP_SHLQBYBI:            issue.shift_count = rb_q[24:28];
            // rotate wraps the byte count at 16
            OP_ROTQBYBI:            issue.shift_count = {1'b0, rb_q[25:28]};
            default:                issue.shift_count = 5'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/odd_issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

interface odd_issue_if;
    import odd_pipe_pkg::*;

    unit_t                  unit;
    perm_kind_t             perm_kind;
    logic [0:4]             shift_count;
    branch_kind_t           branch_kind;
    logic                   set_link;
    logic [0:`ODD_QUAD_W-1] ra;
    logic [0:15]            imm16;
    logic [0:`ODD_ADDR_W-1] pc;
    logic [0:`ODD_RT_W-1]   rt_addr;

    modport decode (
        output unit, perm_kind, shift_count, branch_kind, set_link,
        output ra, imm16, pc, rt_addr
    );

    modport perm (input unit, perm_kind, shift_count, ra);

    modport branch (input unit, branch_kind, ra, imm16, pc);

    // writeback side only needs target and link flag
    modport result (input unit, set_link, rt_addr);

endinterface

`default_nettype wire

// ==== source/odd_pipe_pkg.sv ====
`default_nettype none

`include "odd_pipe_cfg.svh"

package odd_pipe_pkg;

    // odd pipe opcodes, nop is the bubble
    typedef enum logic [4:0] {
        OP_NOP,
        OP_SHLQBI,
        OP_SHLQBII,
        OP_SHLQBY,
        OP_SHLQBYI,
        OP_SHLQBYBI,
        OP_ROTQBI,
        OP_ROTQBII,
        OP_ROTQBY,
        OP_ROTQBYI,
        OP_ROTQBYBI,
        OP_GBB,
        OP_GBH,
        OP_GB,
        OP_BR,
        OP_BRA,
        OP_BRSL,
        OP_BRASL,
        OP_BRZ,
        OP_BRNZ,
        OP_BRHZ,
        OP_BRHNZ
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_PERM,
        UNIT_BRANCH
    } unit_t;

    typedef enum logic [2:0] {
        PK_SHIFT_BITS,
        PK_SHIFT_BYTES,
        PK_ROT_BITS,
        PK_ROT_BYTES,
        PK_GATHER_BYTES,
        PK_GATHER_HALFS,
        PK_GATHER_WORDS
    } perm_kind_t;

    typedef enum logic [2:0] {
        BK_REL,
        BK_ABS,
        BK_ZERO_WORD,
        BK_NZ_WORD,
        BK_ZERO_HALF,
        BK_NZ_HALF
    } branch_kind_t;

    // 143 bit result entry, uid in the top bits
    typedef struct packed {
        logic [0:`ODD_UID_W-1]  uid;
        logic [0:`ODD_QUAD_W-1] value;
        logic                   wr_en;
        logic [0:`ODD_RT_W-1]   rt_addr;
        logic [0:`ODD_LAT_W-1]  latency;
    } fw_entry_t;

endpackage

`default_nettype wire

// ==== source/odd_pipe_cfg.svh ====
`ifndef ODD_PIPE_CFG_SVH
`define ODD_PIPE_CFG_SVH

// operand and address widths
`define ODD_QUAD_W 128
`define ODD_ADDR_W 32
`define ODD_RT_W 7

// forwarding entry fields
`define ODD_LAT_W 4
`define ODD_UID_W 3

// result stages from execute to writeback
`define ODD_FW_DEPTH 7

// permute unit
`define ODD_PERM_UID 5
`define ODD_PERM_LAT 4

// branch unit
`define ODD_BR_UID 7
`define ODD_BR_LAT 1

`endif
